/* verilog/dsp_pkg.sv */
// DSP shared types package with the operand widths, opcodes and lane structs.

package dsp_pkg;

    ////////////////////
    // widths
    ////////////////////

    // A and B operand width.
    localparam int DSP_A_W = 18;
    // C operand and P result width.
    localparam int DSP_C_W = 48;

    ////////////////////
    // opcodes
    ////////////////////

    // codes not listed here execute as pass.
    typedef enum logic [7:0] {
        OP_PASS   = 8'h00,
        OP_MUL    = 8'h01,
        OP_MULADD = 8'h02,
        OP_MULSUB = 8'h03,
        OP_ADD    = 8'h04
    } dsp_op_t;

    ////////////////////
    // bus payloads
    ////////////////////

    // operands of one lane.
    typedef struct packed {
        logic signed [DSP_A_W-1:0] a;
        logic signed [DSP_A_W-1:0] b;
        logic signed [DSP_C_W-1:0] c;
    } dsp_lane_t;

    // one command, both lanes run the same op.
    typedef struct packed {
        dsp_op_t   op;
        dsp_lane_t lane_l;
        dsp_lane_t lane_r;
    } dsp_cmd_t;

    // lane results, wrapped to 48 bits.
    typedef struct packed {
        logic [DSP_C_W-1:0] p_l;
        logic [DSP_C_W-1:0] p_r;
    } dsp_res_t;

endpackage

/* verilog/dsp_if.sv */
// DSP bus link carrying one four-phase req/ack transaction between client and server.

`timescale 1ns/1ps

interface dsp_if;

    import dsp_pkg::*;

    ////////////////////
    // handshake
    ////////////////////

    // raised by the client with cmd stable.
    logic req;
    // raised by the server once res is valid.
    logic ack;

    ////////////////////
    // payload
    ////////////////////

    // held by the client while req is high.
    dsp_cmd_t cmd;
    // held by the server while ack is high.
    dsp_res_t res;

    // requesting side.
    modport client (
        output req,
        output cmd,
        input  ack,
        input  res
    );

    // serving side.
    modport server (
        input  req,
        input  cmd,
        output ack,
        output res
    );

    // sequence is req up, ack up, req down, ack down.
    // a new req waits for ack low.

endinterface

/* verilog/dsp_client_port.sv */
// DSP client port that registers one outside command and runs it over the shared bus.

`timescale 1ns/1ps

module dsp_client_port (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ch_req,
    output logic              ch_ack,
    input  dsp_pkg::dsp_cmd_t ch_cmd,
    output dsp_pkg::dsp_res_t ch_res,
    dsp_if.client             bus
);

    import dsp_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_DONE
    } state_t;

    state_t   state_q;
    logic     req_q;
    logic     ack_q;
    logic     take;
    dsp_cmd_t cmd_q;
    dsp_res_t res_q;

    // new command once the previous bus ack is gone.
    assign take = (state_q == ST_IDLE) && ch_req && !bus.ack;

    ////////////////////
    // sequencer
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            req_q   <= 1'b0;
            ack_q   <= 1'b0;
            res_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (take) begin
                        req_q   <= 1'b1;
                        state_q <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    // result is valid with bus ack.
                    if (bus.ack) begin
                        res_q   <= bus.res;
                        req_q   <= 1'b0;
                        ack_q   <= 1'b1;
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (!ch_req) begin
                        ack_q   <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // command copy frees the outside channel.
    always_ff @(posedge clk) begin
        if (take) begin
            cmd_q <= ch_cmd;
        end
    end

    assign bus.req = req_q;
    assign bus.cmd = cmd_q;
    assign ch_ack  = ack_q;
    assign ch_res  = res_q;

    // channel ack rises with bus req low, and the server drops its ack next.
    a_ack_after_bus: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ch_ack) |-> !bus.req ##1 !bus.ack);

endmodule

/* verilog/dsp_arb_rr.sv */
// DSP round-robin arbiter that holds one grant until its bus transaction completes.

`timescale 1ns/1ps

module dsp_arb_rr #(
    parameter int CLIENTS_N = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [CLIENTS_N-1:0] req,
    input  logic                 done,
    output logic [CLIENTS_N-1:0] gnt
);

    localparam int IDX_W = (CLIENTS_N > 1) ? $clog2(CLIENTS_N) : 1;

    logic [CLIENTS_N-1:0] gnt_q;
    logic [IDX_W-1:0]     last_q;
    logic [IDX_W-1:0]     pick;
    logic                 found;

    ////////////////////
    // next requester
    ////////////////////

    // search begins right after the last client served.
    always_comb begin
        int idx;
        pick  = '0;
        found = 1'b0;
        for (int k = 1; k <= CLIENTS_N; k++) begin
            idx = (int'(last_q) + k) % CLIENTS_N;
            if (!found && req[idx]) begin
                found = 1'b1;
                pick  = IDX_W'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_q  <= '0;
            // client 0 goes first.
            last_q <= IDX_W'(CLIENTS_N - 1);
        end else if (gnt_q == '0) begin
            if (found) begin
                gnt_q       <= '0;
                gnt_q[pick] <= 1'b1;
                last_q      <= pick;
            end
        end else if (done) begin
            gnt_q <= '0;
        end
    end

    assign gnt = gnt_q;

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(gnt));

endmodule

/* verilog/dsp_nic.sv */
// DSP interconnect that steers the granted client link onto the slice and returns its results.

`timescale 1ns/1ps

module dsp_nic #(
    parameter int CLIENTS_N = 2
) (
    input  logic  clk,
    input  logic  rst_n,
    dsp_if.server clients [CLIENTS_N],
    dsp_if.client slice
);

    import dsp_pkg::*;

    logic [CLIENTS_N-1:0] req_vec;
    logic [CLIENTS_N-1:0] gnt;
    logic                 ack_q;
    logic                 done;
    dsp_cmd_t             cmd_arr [CLIENTS_N];

    ////////////////////
    // arbitration
    ////////////////////

    dsp_arb_rr #(
        .CLIENTS_N (CLIENTS_N)
    ) i_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req_vec),
        .done  (done),
        .gnt   (gnt)
    );

    // previous slice ack for the falling edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= slice.ack;
        end
    end

    // transaction ends when ack falls under a held grant.
    assign done = ack_q && !slice.ack && (|gnt);

    ////////////////////
    // client side
    ////////////////////

    for (genvar i = 0; i < CLIENTS_N; i++) begin : g_client
        assign req_vec[i]     = clients[i].req;
        assign cmd_arr[i]     = clients[i].cmd;
        // other clients see ack low and zero res.
        assign clients[i].ack = gnt[i] & slice.ack;
        assign clients[i].res = gnt[i] ? slice.res : '0;
    end

    ////////////////////
    // slice side
    ////////////////////

    always_comb begin
        slice.cmd = '0;
        for (int k = 0; k < CLIENTS_N; k++) begin
            if (gnt[k]) begin
                slice.cmd = cmd_arr[k];
            end
        end
    end

    assign slice.req = |(req_vec & gnt);

    // slice req only comes from one granted client after the last slice ack fell.
    a_req_needs_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(slice.req) |-> $onehot(gnt) && !slice.ack);

endmodule

/* verilog/dsp_slice.sv */
// DSP slice with two multiply-accumulate lanes behind a four-phase server link.

`timescale 1ns/1ps

module dsp_slice #(
    // two or more, the product stage takes one cycle.
    parameter int SLICE_LAT = 2
) (
    input  logic  clk,
    input  logic  rst_n,
    dsp_if.server bus
);

    import dsp_pkg::*;

    localparam int PROD_W = 2 * DSP_A_W;

    logic                 req_q;
    logic                 start;
    logic [SLICE_LAT-1:0] vld_q;
    logic                 ack_q;
    dsp_cmd_t             cmd_q;
    logic signed [PROD_W-1:0] prod_l_q;
    logic signed [PROD_W-1:0] prod_r_q;
    dsp_res_t             res_q;

    // final stage of one lane.
    function automatic logic [DSP_C_W-1:0] lane_calc(
        input dsp_op_t                  op,
        input dsp_lane_t                ln,
        input logic signed [PROD_W-1:0] prod
    );
        logic [DSP_C_W-1:0] m;
        logic [DSP_C_W-1:0] a_x;
        logic [DSP_C_W-1:0] r;
        m   = {{(DSP_C_W-PROD_W){prod[PROD_W-1]}}, prod};
        a_x = {{(DSP_C_W-DSP_A_W){ln.a[DSP_A_W-1]}}, ln.a};
        case (op)
            OP_MUL:    r = m;
            OP_MULADD: r = m + ln.c;
            OP_MULSUB: r = ln.c - m;
            OP_ADD:    r = a_x + ln.c;
            default:   r = ln.c;
        endcase
        return r;
    endfunction

    assign start = bus.req & ~req_q;

    ////////////////////
    // control
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
            vld_q <= '0;
            ack_q <= 1'b0;
        end else begin
            req_q    <= bus.req;
            vld_q[0] <= start;
            for (int k = 1; k < SLICE_LAT; k++) begin
                vld_q[k] <= vld_q[k-1];
            end
            if (vld_q[SLICE_LAT-1]) begin
                ack_q <= 1'b1;
            end else if (!bus.req) begin
                ack_q <= 1'b0;
            end
        end
    end

    ////////////////////
    // datapath
    ////////////////////

    always_ff @(posedge clk) begin
        if (start) begin
            cmd_q <= bus.cmd;
        end
        prod_l_q <= $signed(cmd_q.lane_l.a) * $signed(cmd_q.lane_l.b);
        prod_r_q <= $signed(cmd_q.lane_r.a) * $signed(cmd_q.lane_r.b);
        // result lands with ack.
        if (vld_q[SLICE_LAT-1]) begin
            res_q.p_l <= lane_calc(cmd_q.op, cmd_q.lane_l, prod_l_q);
            res_q.p_r <= lane_calc(cmd_q.op, cmd_q.lane_r, prod_r_q);
        end
    end

    assign bus.ack = ack_q;
    assign bus.res = res_q;

    a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus.req && $past(bus.req) |-> $stable(bus.cmd));

endmodule

/* verilog/dsp_subsys.sv */
// DSP subsystem top that shares one two-lane slice among several client channels.

`timescale 1ns/1ps

module dsp_subsys #(
    parameter int CLIENTS_N = 2,
    parameter int SLICE_LAT = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [CLIENTS_N-1:0]                   ch_req,
    output logic [CLIENTS_N-1:0]                   ch_ack,
    input  logic [8*CLIENTS_N-1:0]                 ch_op,
    input  logic [dsp_pkg::DSP_A_W*CLIENTS_N-1:0]  ch_al,
    input  logic [dsp_pkg::DSP_A_W*CLIENTS_N-1:0]  ch_bl,
    input  logic [dsp_pkg::DSP_C_W*CLIENTS_N-1:0]  ch_cl,
    input  logic [dsp_pkg::DSP_A_W*CLIENTS_N-1:0]  ch_ar,
    input  logic [dsp_pkg::DSP_A_W*CLIENTS_N-1:0]  ch_br,
    input  logic [dsp_pkg::DSP_C_W*CLIENTS_N-1:0]  ch_cr,
    output logic [dsp_pkg::DSP_C_W*CLIENTS_N-1:0]  ch_pl,
    output logic [dsp_pkg::DSP_C_W*CLIENTS_N-1:0]  ch_pr
);

    import dsp_pkg::*;

    // one link per client, one to the slice.
    dsp_if cl_link [CLIENTS_N] ();
    dsp_if sl_link ();

    ////////////////////
    // client channels
    ////////////////////

    for (genvar i = 0; i < CLIENTS_N; i++) begin : g_ch
        dsp_cmd_t cmd;
        dsp_res_t res;

        // unlisted op codes pass through and execute as pass.
        assign cmd = '{
            op:     dsp_op_t'(ch_op[8*i +: 8]),
            lane_l: '{a: ch_al[DSP_A_W*i +: DSP_A_W],
                      b: ch_bl[DSP_A_W*i +: DSP_A_W],
                      c: ch_cl[DSP_C_W*i +: DSP_C_W]},
            lane_r: '{a: ch_ar[DSP_A_W*i +: DSP_A_W],
                      b: ch_br[DSP_A_W*i +: DSP_A_W],
                      c: ch_cr[DSP_C_W*i +: DSP_C_W]}
        };

        dsp_client_port i_port (
            .clk    (clk),
            .rst_n  (rst_n),
            .ch_req (ch_req[i]),
            .ch_ack (ch_ack[i]),
            .ch_cmd (cmd),
            .ch_res (res),
            .bus    (cl_link[i])
        );

        assign ch_pl[DSP_C_W*i +: DSP_C_W] = res.p_l;
        assign ch_pr[DSP_C_W*i +: DSP_C_W] = res.p_r;
    end

    ////////////////////
    // shared resource
    ////////////////////

    dsp_nic #(
        .CLIENTS_N (CLIENTS_N)
    ) i_nic (
        .clk     (clk),
        .rst_n   (rst_n),
        .clients (cl_link),
        .slice   (sl_link)
    );

    dsp_slice #(
        .SLICE_LAT (SLICE_LAT)
    ) i_slice (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (sl_link)
    );

endmodule

/* verif/tb_dsp_subsys.sv */
// DSP subsystem testbench that runs three clients against the shared slice from a table.

`timescale 1ns/1ps

module tb_dsp_subsys;

    import dsp_pkg::*;

    localparam int CLIENTS_N    = 3;
    localparam int CYC_PER_TEST = CLIENTS_N * 12 + 20;

    logic                         clk;
    logic                         rst_n;
    logic [CLIENTS_N-1:0]         ch_req, ch_ack;
    logic [8*CLIENTS_N-1:0]       ch_op;
    logic [DSP_A_W*CLIENTS_N-1:0] ch_al, ch_bl, ch_ar, ch_br;
    logic [DSP_C_W*CLIENTS_N-1:0] ch_cl, ch_cr, ch_pl, ch_pr;

    // one table row with its expected lane results.
    typedef struct packed {
        int                 client;
        logic [7:0]         op;
        logic [DSP_A_W-1:0] al, bl, ar, br;
        logic [DSP_C_W-1:0] cl, cr;
        int                 hold;
        logic [DSP_C_W-1:0] exp_pl, exp_pr;
    } test_t;

    test_t                tests [$];
    int                   order_q [$];
    int                   last_idx [CLIENTS_N];
    int                   wait_from [CLIENTS_N];
    logic [CLIENTS_N-1:0] ack_prev;
    logic [CLIENTS_N-1:0] req_prev;
    int                   errors;
    int                   done_cnt;
    int                   cycles;
    int                   limit;

    dsp_subsys #(.CLIENTS_N(CLIENTS_N)) i_dsp_subsys (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////
    // reference model
    ////////////////////

    // one lane, 48-bit wrap on every operation.
    function automatic logic [DSP_C_W-1:0] expect_lane(input logic [7:0] op,
            input logic [DSP_A_W-1:0] a, input logic [DSP_A_W-1:0] b,
            input logic [DSP_C_W-1:0] c);
        logic signed [DSP_C_W-1:0] sa;
        logic signed [DSP_C_W-1:0] sb;
        sa = {{(DSP_C_W-DSP_A_W){a[DSP_A_W-1]}}, a};
        sb = {{(DSP_C_W-DSP_A_W){b[DSP_A_W-1]}}, b};
        case (op)
            OP_MUL:    return sa * sb;
            OP_MULADD: return sa * sb + c;
            OP_MULSUB: return c - sa * sb;
            OP_ADD:    return sa + c;
            default:   return c;
        endcase
    endfunction

    function automatic void add_test(input int c, input logic [7:0] op,
            input logic [DSP_A_W-1:0] al, input logic [DSP_A_W-1:0] bl,
            input logic [DSP_C_W-1:0] cl, input logic [DSP_A_W-1:0] ar,
            input logic [DSP_A_W-1:0] br, input logic [DSP_C_W-1:0] cr, input int hold);
        test_t t;
        t = '{c, op, al, bl, ar, br, cl, cr, hold,
              expect_lane(op, al, bl, cl), expect_lane(op, ar, br, cr)};
        tests.push_back(t);
    endfunction

    ////////////////////
    // driver
    ////////////////////

    // inputs move 1 ns after the rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic int check_result(input int c, input int n, input test_t t);
        int bad;
        bad = 0;
        if (ch_pl[DSP_C_W*c +: DSP_C_W] !== t.exp_pl) begin
            $display("mismatch ch_pl[%0d] test %0d: got %h, expected %h",
                     c, n, ch_pl[DSP_C_W*c +: DSP_C_W], t.exp_pl);
            bad++;
        end
        if (ch_pr[DSP_C_W*c +: DSP_C_W] !== t.exp_pr) begin
            $display("mismatch ch_pr[%0d] test %0d: got %h, expected %h",
                     c, n, ch_pr[DSP_C_W*c +: DSP_C_W], t.exp_pr);
            bad++;
        end
        return bad;
    endfunction

    task automatic drive_client(input int c);
        test_t t;
        int    bad;
        int    base;
        bit    first;
        first = 1'b1;
        for (int n = 0; n < tests.size(); n++) begin
            if (tests[n].client == c) begin
                t   = tests[n];
                bad = 0;
                // first rows of all clients start together.
                if (!first) begin
                    repeat ($urandom % 4) next_cycle();
                end
                first = 1'b0;
                ch_op[8*c +: 8]             = t.op;
                ch_al[DSP_A_W*c +: DSP_A_W] = t.al;
                ch_bl[DSP_A_W*c +: DSP_A_W] = t.bl;
                ch_cl[DSP_C_W*c +: DSP_C_W] = t.cl;
                ch_ar[DSP_A_W*c +: DSP_A_W] = t.ar;
                ch_br[DSP_A_W*c +: DSP_A_W] = t.br;
                ch_cr[DSP_C_W*c +: DSP_C_W] = t.cr;
                ch_req[c] = 1'b1;
                next_cycle();
                while (!ch_ack[c]) begin
                    next_cycle();
                end
                bad += check_result(c, n, t);
                // held request, results stay while others are served.
                if (t.hold > 0) begin
                    base = order_q.size();
                    repeat (t.hold) begin
                        next_cycle();
                        bad += check_result(c, n, t);
                        if (!ch_ack[c]) begin
                            $display("client %0d lost ch_ack while ch_req was held", c);
                            bad++;
                        end
                    end
                    if (order_q.size() == base) begin
                        $display("no other client was served while client %0d held", c);
                        bad++;
                    end
                end
                ch_req[c] = 1'b0;
                next_cycle();
                while (ch_ack[c]) begin
                    next_cycle();
                end
                $display("test %0d client %0d op %02h done with %0d errors", n, c, t.op, bad);
                errors += bad;
                done_cnt++;
            end
        end
    endtask

    ////////////////////
    // service order
    ////////////////////

    // sampled mid cycle. nobody may be served twice while another waits.
    always @(negedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < CLIENTS_N; i++) begin
                if (ch_ack[i] && !ack_prev[i]) begin
                    for (int j = 0; j < CLIENTS_N; j++) begin
                        if (j != i && ch_req[j] && !ch_ack[j]
                                && wait_from[j] <= last_idx[i]) begin
                            $display("client %0d served twice while client %0d waits", i, j);
                            errors++;
                        end
                    end
                    last_idx[i] = order_q.size();
                    order_q.push_back(i);
                end
            end
            for (int i = 0; i < CLIENTS_N; i++) begin
                if (ch_req[i] && !req_prev[i]) begin
                    wait_from[i] = order_q.size();
                end
            end
            ack_prev = ch_ack;
            req_prev = ch_req;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, a handshake never completed", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        void'($urandom(32'h8d5f));
        rst_n    = 1'b0;
        ch_req   = '0;
        ch_op    = '0;
        ch_al    = '0;
        ch_bl    = '0;
        ch_cl    = '0;
        ch_ar    = '0;
        ch_br    = '0;
        ch_cr    = '0;
        ack_prev = '0;
        req_prev = '0;
        errors   = 0;
        done_cnt = 0;
        cycles   = 0;
        for (int i = 0; i < CLIENTS_N; i++) begin
            last_idx[i]  = -1;
            wait_from[i] = 0;
        end

        // client, op, left a b c, right a b c, cycles held after ack.
        add_test(0, OP_MUL, 18'h00123, 18'h3fffd, 48'h0,
                 18'h1ffff, 18'h1ffff, 48'h0, 0);
        add_test(0, OP_MULADD, 18'h20000, 18'h20000, 48'h7fff_ffff_ffff,
                 18'h00010, 18'h3fff0, 48'h1000, 0);
        add_test(0, OP_ADD, 18'h3ffff, 18'h00000, 48'hffff_ffff_ffff,
                 18'h00005, 18'h0007f, 48'h8000_0000_0000, 30);
        add_test(0, OP_MULSUB, 18'h00100, 18'h00200, 48'h8000_0000_0000,
                 18'h3ff00, 18'h00100, 48'h1, 0);
        add_test(1, OP_MULADD, 18'h3fffe, 18'h00003, 48'h10,
                 18'h0abcd, 18'h01234, 48'hffff_ffff_0000, 0);
        add_test(1, OP_PASS, 18'h1ffff, 18'h1ffff, 48'h0000_dead_beef,
                 18'h20000, 18'h3ffff, 48'h8000_0000_0001, 0);
        add_test(1, OP_MUL, 18'h20000, 18'h1ffff, 48'h5,
                 18'h3ffff, 18'h3ffff, 48'h7, 0);
        add_test(1, 8'h5a, 18'h1abcd, 18'h2dcba, 48'h1234_5678_9abc,
                 18'h00001, 18'h00002, 48'hfedc_ba98_7654, 0);
        add_test(2, OP_MULSUB, 18'h00400, 18'h3fc00, 48'h0,
                 18'h1ffff, 18'h20000, 48'h8000_0000_0000, 0);
        add_test(2, 8'hff, 18'h00001, 18'h00002, 48'hffff_ffff_ffff,
                 18'h00003, 18'h00004, 48'h0123_4567_89ab, 0);
        add_test(2, OP_MULADD, 18'h3ffff, 18'h3ffff, 48'hffff_ffff_ffff,
                 18'h20000, 18'h20000, 48'h7fff_fffc_0000, 0);
        add_test(2, OP_ADD, 18'h20000, 18'h00000, 48'h8000_0000_0000,
                 18'h1ffff, 18'h00000, 48'h7fff_ffff_ffff, 0);
        limit = tests.size() * CYC_PER_TEST;

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        if (ch_ack !== '0) begin
            $display("mismatch ch_ack after reset: got %h, expected 0", ch_ack);
            errors++;
        end
        if (ch_pl !== '0) begin
            $display("mismatch ch_pl after reset: got %h, expected 0", ch_pl);
            errors++;
        end
        if (ch_pr !== '0) begin
            $display("mismatch ch_pr after reset: got %h, expected 0", ch_pr);
            errors++;
        end
        $display("test reset done with %0d errors", errors);
        done_cnt++;

        fork
            drive_client(0);
            drive_client(1);
            drive_client(2);
        join

        $display("%0d tests finished, %0d errors", done_cnt, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
verilog/dsp_pkg.sv
verilog/dsp_if.sv
verilog/dsp_client_port.sv
verilog/dsp_arb_rr.sv
verilog/dsp_nic.sv
verilog/dsp_slice.sv
verilog/dsp_subsys.sv
verif/tb_dsp_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the DSP subsystem testbench.
# The result is taken from the status line in sim.log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dsp_subsys -f filelist.f -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vtb_dsp_subsys > sim.log 2>&1 \
    || echo "build or simulation ended with an error"

cat build.log
[ -f sim.log ] && cat sim.log

grep -qx "STATUS: PASS" sim.log && echo "simulation passed" && exit 0
echo "simulation failed"
exit 1
